// File: camera_pipeline_pkg.sv
/* Pixel formats shared by the stream stages. Bayer samples and RGB channels are 10 bits,
   metering means keep the top 8 bits of each channel */
package camera_pipeline_pkg;

    localparam int COORD_WIDTH = 11; // Covers lines up to 2047 pixels

    typedef logic [9:0] bayer_t;

    typedef struct packed {
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } rgb_pixel_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } metering_t;

endpackage

// File: camera_registers_pkg.sv
/* Host op codes, none of which take an operand. OP_START_CAPTURE is the only code
   that gives no response */
package camera_registers_pkg;

    localparam logic [7:0] OP_START_CAPTURE = 8'h10;
    localparam logic [7:0] OP_READ_STATUS   = 8'h11;
    localparam logic [7:0] OP_READ_RED      = 8'h12;
    localparam logic [7:0] OP_READ_GREEN    = 8'h13;
    localparam logic [7:0] OP_READ_BLUE     = 8'h14;
    localparam logic [7:0] OP_READ_BYTES_HI = 8'h15;
    localparam logic [7:0] OP_READ_BYTES_LO = 8'h16;
    localparam logic [7:0] OP_READ_DATA     = 8'h20;
    localparam logic [7:0] OP_RESET_READ    = 8'h21;

    localparam int STATUS_CAPTURE_DONE = 0; // Bit index in the status byte

    localparam logic [7:0] RESPONSE_ACK = 8'h01; // Answer to OP_RESET_READ

endpackage

// File: buffer_read_if.sv
/* Read path between the image buffer and the register block. Channel 0 is red,
   1 green, 2 blue; bytes_available counts bytes, not pixels */
`timescale 1ns/1ps

interface buffer_read_if #(
    parameter int BUFFER_PIXELS = 256
);
    localparam int PIXEL_WIDTH = $clog2(BUFFER_PIXELS);

    logic                   start_capture;   // One-cycle pulse
    logic [PIXEL_WIDTH-1:0] read_pixel;
    logic [1:0]             read_channel;
    logic [7:0]             read_data;       // Combinational from the buffer memory
    logic [15:0]            bytes_available;
    logic                   capture_done;

    modport buffer (
        input  start_capture, read_pixel, read_channel,
        output read_data, bytes_available, capture_done
    );

    modport registers (
        output start_capture, read_pixel, read_channel,
        input  read_data, bytes_available, capture_done
    );

endinterface

// File: crop.sv
/* Window crop, one cycle of latency. Bounds are start inclusive and end exclusive,
   y counts falling line edges, so blanking between lines is required */
`timescale 1ns/1ps

module crop import camera_pipeline_pkg::*; #(
    parameter type payload_t = bayer_t,
    parameter int  X_START   = 0,
    parameter int  X_END     = 16,
    parameter int  Y_START   = 0,
    parameter int  Y_END     = 16
) (
    input  logic     mipi_byte_clock,
    input  logic     mipi_byte_reset_n,
    input  logic     frame_valid_i,
    input  logic     line_valid_i,
    input  payload_t data_i,
    output logic     frame_valid_o,
    output logic     line_valid_o,
    output payload_t data_o
);
    logic [COORD_WIDTH-1:0] x_count;
    logic [COORD_WIDTH-1:0] y_count;
    logic                   line_valid_d;
    logic                   in_window;

    assign in_window = x_count >= COORD_WIDTH'(X_START) && x_count < COORD_WIDTH'(X_END) &&
                       y_count >= COORD_WIDTH'(Y_START) && y_count < COORD_WIDTH'(Y_END);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            y_count       <= '0;
            line_valid_d  <= 1'b0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
        end else begin
            frame_valid_o <= frame_valid_i;
            line_valid_o  <= line_valid_i && in_window;
            line_valid_d  <= line_valid_i;
            x_count       <= line_valid_i ? x_count + 1'b1 : '0;
            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_d && !line_valid_i) begin
                y_count <= y_count + 1'b1; // Line just ended
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_o <= data_i;
    end

endmodule

// File: debayer.sv
/* 2x2 debayer, one cycle of latency. Drops the first line and first column of each frame,
   so the output is one smaller in each direction; lines must fit in MAX_LINE_WIDTH */
`timescale 1ns/1ps

module debayer import camera_pipeline_pkg::*; #(
    parameter int MAX_LINE_WIDTH = 64,
    parameter int X_PHASE        = 0,
    parameter int Y_PHASE        = 0
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       frame_valid_i,
    input  logic       line_valid_i,
    input  bayer_t     bayer_data_i,
    output logic       frame_valid_o,
    output logic       line_valid_o,
    output rgb_pixel_t rgb_data_o
);
    localparam int ADDR_WIDTH = $clog2(MAX_LINE_WIDTH);

    bayer_t                line_buffer [MAX_LINE_WIDTH];
    bayer_t                above;      // Sample at (x, y-1)
    bayer_t                above_left; // Sample at (x-1, y-1)
    bayer_t                left;       // Sample at (x-1, y)
    logic [ADDR_WIDTH-1:0] x_count;
    logic                  line_valid_d;
    logic                  first_line;
    logic                  y_odd;
    logic                  x_site;
    logic                  y_site;
    logic [10:0]           green_sum;
    rgb_pixel_t            rgb;

    assign above  = line_buffer[x_count];
    assign x_site = x_count[0] ^ X_PHASE[0];
    assign y_site = y_odd ^ Y_PHASE[0];

    // Current sample sits at the bottom right of the block
    always_comb begin
        case ({y_site, x_site})
            2'b00: begin
                rgb.red   = bayer_data_i;
                rgb.blue  = above_left;
                green_sum = above + left;
            end
            2'b01: begin
                rgb.red   = left;
                rgb.blue  = above;
                green_sum = above_left + bayer_data_i;
            end
            2'b10: begin
                rgb.red   = above;
                rgb.blue  = left;
                green_sum = above_left + bayer_data_i;
            end
            default: begin
                rgb.red   = above_left;
                rgb.blue  = bayer_data_i;
                green_sum = above + left;
            end
        endcase
        rgb.green = green_sum[10:1]; // Mean of the two green sites
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            line_valid_d  <= 1'b0;
            first_line    <= 1'b1;
            y_odd         <= 1'b0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
        end else begin
            frame_valid_o <= frame_valid_i;
            line_valid_o  <= line_valid_i && !first_line && x_count != '0;
            line_valid_d  <= line_valid_i;
            x_count       <= line_valid_i ? x_count + 1'b1 : '0;
            if (!frame_valid_i) begin
                first_line <= 1'b1;
                y_odd      <= 1'b0;
            end else if (line_valid_d && !line_valid_i) begin
                first_line <= 1'b0;
                y_odd      <= !y_odd;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (line_valid_i) begin
            line_buffer[x_count] <= bayer_data_i;
            above_left           <= above;
            left                 <= bayer_data_i;
        end
        rgb_data_o <= rgb;
    end

endmodule

// File: metering.sv
/* Per-frame channel means from the top 8 bits of each channel.
   The frame must hold exactly 2**LOG2_PIXELS pixels for the means to be exact */
`timescale 1ns/1ps

module metering import camera_pipeline_pkg::*; #(
    parameter int LOG2_PIXELS = 8
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       frame_valid_i,
    input  logic       line_valid_i,
    input  rgb_pixel_t rgb_data_i,
    output metering_t  metering_o
);
    localparam int SUM_WIDTH = 8 + LOG2_PIXELS;

    logic [SUM_WIDTH-1:0] red_sum;
    logic [SUM_WIDTH-1:0] green_sum;
    logic [SUM_WIDTH-1:0] blue_sum;
    logic                 frame_valid_d;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
            frame_valid_d <= 1'b0;
            metering_o    <= '0;
        end else begin
            frame_valid_d <= frame_valid_i;
            if (frame_valid_d && !frame_valid_i) begin
                metering_o.red   <= red_sum[LOG2_PIXELS +: 8]; // Sum divided by pixel count
                metering_o.green <= green_sum[LOG2_PIXELS +: 8];
                metering_o.blue  <= blue_sum[LOG2_PIXELS +: 8];
                red_sum          <= '0;
                green_sum        <= '0;
                blue_sum         <= '0;
            end else if (line_valid_i) begin
                red_sum   <= red_sum + SUM_WIDTH'(rgb_data_i.red[9:2]);
                green_sum <= green_sum + SUM_WIDTH'(rgb_data_i.green[9:2]);
                blue_sum  <= blue_sum + SUM_WIDTH'(rgb_data_i.blue[9:2]);
            end
        end
    end

endmodule

// File: image_buffer.sv
/* Single-frame capture of 8-bit RGB. Pixels beyond BUFFER_PIXELS are dropped;
   BUFFER_PIXELS must be a power of two */
`timescale 1ns/1ps

module image_buffer import camera_pipeline_pkg::*; #(
    parameter int BUFFER_PIXELS = 256
) (
    input  logic              mipi_byte_clock,
    input  logic              mipi_byte_reset_n,
    input  logic              frame_valid_i,
    input  logic              line_valid_i,
    input  rgb_pixel_t        rgb_data_i,
    buffer_read_if.buffer     read_port
);
    localparam int ADDR_WIDTH = $clog2(BUFFER_PIXELS);

    logic [2:0][7:0]     pixel_memory [BUFFER_PIXELS]; // Index 0 red, 1 green, 2 blue
    logic [ADDR_WIDTH:0] write_count;
    logic                frame_valid_d;
    logic                armed;
    logic                capturing;
    logic                capture_done;
    logic                frame_start;
    logic                write_enable;

    assign frame_start  = frame_valid_i && !frame_valid_d;
    assign write_enable = capturing && line_valid_i &&
                          write_count < (ADDR_WIDTH + 1)'(BUFFER_PIXELS);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            write_count   <= '0;
            frame_valid_d <= 1'b0;
            armed         <= 1'b0;
            capturing     <= 1'b0;
            capture_done  <= 1'b0;
        end else begin
            frame_valid_d <= frame_valid_i;
            if (read_port.start_capture) begin
                armed        <= 1'b1;
                capture_done <= 1'b0;
            end else if (armed && frame_start) begin
                armed       <= 1'b0;
                capturing   <= 1'b1;
                write_count <= '0;
            end else if (capturing && !frame_valid_i) begin
                capturing    <= 1'b0; // Captured frame has ended
                capture_done <= 1'b1;
            end
            if (write_enable) begin
                write_count <= write_count + 1'b1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (write_enable) begin
            pixel_memory[write_count[ADDR_WIDTH-1:0]] <=
                {rgb_data_i.blue[9:2], rgb_data_i.green[9:2], rgb_data_i.red[9:2]};
        end
    end

    assign read_port.read_data       = pixel_memory[read_port.read_pixel][read_port.read_channel];
    assign read_port.bytes_available = 16'(write_count) * 16'd3;
    assign read_port.capture_done    = capture_done;

endmodule

// File: spi_registers.sv
/* Op code decoder. Responses are registered and valid for one cycle after the op code;
   unknown codes and OP_START_CAPTURE give no response */
`timescale 1ns/1ps

module spi_registers import camera_pipeline_pkg::*, camera_registers_pkg::*; #(
    parameter int BUFFER_PIXELS = 256
) (
    input  logic                  mipi_byte_clock,
    input  logic                  mipi_byte_reset_n,
    input  logic [7:0]            op_code_i,
    input  logic                  op_code_valid_i,
    input  metering_t             metering_i,
    output logic [7:0]            response_o,
    output logic                  response_valid_o,
    buffer_read_if.registers      read_port
);
    localparam int PIXEL_WIDTH = $clog2(BUFFER_PIXELS);

    logic [PIXEL_WIDTH-1:0] read_pixel;
    logic [1:0]             read_channel;
    logic                   start_capture;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o       <= '0;
            response_valid_o <= 1'b0;
            read_pixel       <= '0;
            read_channel     <= '0;
            start_capture    <= 1'b0;
        end else begin
            response_valid_o <= 1'b0;
            start_capture    <= 1'b0;
            if (op_code_valid_i) begin
                response_valid_o <= 1'b1;
                case (op_code_i)
                    OP_START_CAPTURE: begin
                        response_valid_o <= 1'b0;
                        start_capture    <= 1'b1;
                        read_pixel       <= '0;
                        read_channel     <= '0;
                    end
                    OP_READ_STATUS: begin
                        response_o                      <= '0;
                        response_o[STATUS_CAPTURE_DONE] <= read_port.capture_done;
                    end
                    OP_READ_RED:      response_o <= metering_i.red;
                    OP_READ_GREEN:    response_o <= metering_i.green;
                    OP_READ_BLUE:     response_o <= metering_i.blue;
                    OP_READ_BYTES_HI: response_o <= read_port.bytes_available[15:8];
                    OP_READ_BYTES_LO: response_o <= read_port.bytes_available[7:0];
                    OP_READ_DATA: begin
                        response_o <= read_port.read_data;
                        if (read_channel == 2'd2) begin
                            read_channel <= '0; // Blue done, move to next pixel
                            read_pixel   <= read_pixel + 1'b1;
                        end else begin
                            read_channel <= read_channel + 1'b1;
                        end
                    end
                    OP_RESET_READ: begin
                        response_o   <= RESPONSE_ACK;
                        read_pixel   <= '0;
                        read_channel <= '0;
                    end
                    default: response_valid_o <= 1'b0;
                endcase
            end
        end
    end

    assign read_port.start_capture = start_capture;
    assign read_port.read_pixel    = read_pixel;
    assign read_port.read_channel  = read_channel;

endmodule

// File: camera.sv
/* Camera pixel path on one clock. The pan window less one pixel in each direction must
   hold a power-of-two pixel count, and the zoom window is given in debayered coordinates */
`timescale 1ns/1ps

module camera import camera_pipeline_pkg::*; #(
    parameter int PAN_X_START    = 2,
    parameter int PAN_X_END      = 19,
    parameter int PAN_Y_START    = 4,
    parameter int PAN_Y_END      = 21,
    parameter int ZOOM_X_START   = 4,
    parameter int ZOOM_X_END     = 12,
    parameter int ZOOM_Y_START   = 2,
    parameter int ZOOM_Y_END     = 8,
    parameter int MAX_LINE_WIDTH = 64,
    parameter int BUFFER_PIXELS  = 256
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       frame_valid_i,
    input  logic       line_valid_i,
    input  bayer_t     bayer_data_i,
    input  logic [7:0] op_code_i,
    input  logic       op_code_valid_i,
    output logic [7:0] response_o,
    output logic       response_valid_o
);
    localparam int DEBAYER_PIXELS = (PAN_X_END - PAN_X_START - 1) *
                                    (PAN_Y_END - PAN_Y_START - 1);
    localparam int LOG2_PIXELS    = $clog2(DEBAYER_PIXELS);

    logic       panned_frame_valid;
    logic       panned_line_valid;
    bayer_t     panned_data;
    logic       debayered_frame_valid;
    logic       debayered_line_valid;
    rgb_pixel_t debayered_data;
    logic       zoomed_frame_valid;
    logic       zoomed_line_valid;
    rgb_pixel_t zoomed_data;
    metering_t  metering;

    buffer_read_if #(.BUFFER_PIXELS(BUFFER_PIXELS)) buffer_read ();

    crop #(
        .payload_t(bayer_t),
        .X_START(PAN_X_START), .X_END(PAN_X_END),
        .Y_START(PAN_Y_START), .Y_END(PAN_Y_END)
    ) pan_crop (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i, .line_valid_i, .data_i(bayer_data_i),
        .frame_valid_o(panned_frame_valid), .line_valid_o(panned_line_valid),
        .data_o(panned_data)
    );

    debayer #(
        .MAX_LINE_WIDTH(MAX_LINE_WIDTH),
        .X_PHASE(PAN_X_START % 2), // Window origin sets the Bayer phase
        .Y_PHASE(PAN_Y_START % 2)
    ) debayer (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(panned_frame_valid), .line_valid_i(panned_line_valid),
        .bayer_data_i(panned_data),
        .frame_valid_o(debayered_frame_valid), .line_valid_o(debayered_line_valid),
        .rgb_data_o(debayered_data)
    );

    metering #(.LOG2_PIXELS(LOG2_PIXELS)) metering_block (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(debayered_frame_valid), .line_valid_i(debayered_line_valid),
        .rgb_data_i(debayered_data), .metering_o(metering)
    );

    crop #(
        .payload_t(rgb_pixel_t),
        .X_START(ZOOM_X_START), .X_END(ZOOM_X_END),
        .Y_START(ZOOM_Y_START), .Y_END(ZOOM_Y_END)
    ) zoom_crop (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(debayered_frame_valid), .line_valid_i(debayered_line_valid),
        .data_i(debayered_data),
        .frame_valid_o(zoomed_frame_valid), .line_valid_o(zoomed_line_valid),
        .data_o(zoomed_data)
    );

    image_buffer #(.BUFFER_PIXELS(BUFFER_PIXELS)) image_buffer (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(zoomed_frame_valid), .line_valid_i(zoomed_line_valid),
        .rgb_data_i(zoomed_data), .read_port(buffer_read.buffer)
    );

    spi_registers #(.BUFFER_PIXELS(BUFFER_PIXELS)) spi_registers (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .op_code_i, .op_code_valid_i, .metering_i(metering),
        .response_o, .response_valid_o, .read_port(buffer_read.registers)
    );

endmodule

// File: camera_checker.sv
/* Reference model of the camera pixel path and its op code responses. Windows must match
   the DUT, and op codes must come at least ten cycles after a frame ends */
`timescale 1ns/1ps

module camera_checker import camera_pipeline_pkg::*, camera_registers_pkg::*; #(
    parameter int FRAME_WIDTH   = 24,
    parameter int FRAME_HEIGHT  = 24,
    parameter int PAN_X_START   = 2,
    parameter int PAN_X_END     = 19,
    parameter int PAN_Y_START   = 4,
    parameter int PAN_Y_END     = 21,
    parameter int ZOOM_X_START  = 4,
    parameter int ZOOM_X_END    = 12,
    parameter int ZOOM_Y_START  = 2,
    parameter int ZOOM_Y_END    = 8,
    parameter int BUFFER_PIXELS = 256
) (
    input logic       mipi_byte_clock,
    input logic       mipi_byte_reset_n,
    input logic       frame_valid_i,
    input logic       line_valid_i,
    input bayer_t     bayer_data_i,
    input logic [7:0] op_code_i,
    input logic       op_code_valid_i,
    input logic [7:0] response_i,
    input logic       response_valid_i
);
    localparam int DEBAYER_WIDTH  = PAN_X_END - PAN_X_START - 1;
    localparam int DEBAYER_HEIGHT = PAN_Y_END - PAN_Y_START - 1;
    localparam int LOG2_PIXELS    = $clog2(DEBAYER_WIDTH * DEBAYER_HEIGHT);

    bayer_t     frame [FRAME_HEIGHT][FRAME_WIDTH];
    logic [7:0] captured [$];   // Buffer bytes in R, G, B order
    metering_t  means;
    int         x;
    int         y;
    int         read_index;
    logic       frame_valid_d;
    logic       line_valid_d;
    logic       armed;
    logic       capturing;
    logic       capture_done;
    logic       pending;
    logic [7:0] pending_op;
    logic [7:0] expected;
    int         error_count = 0;
    int         check_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         errors_at_close = 0;

    // Input coordinates of the block's top left are the debayered pixel plus the pan start
    function automatic rgb_pixel_t debayer_pixel(input int dx, input int dy);
        rgb_pixel_t  pixel;
        logic [10:0] green_sum;
        int          ix;
        int          iy;
        pixel     = '0;
        green_sum = '0;
        for (int by = 0; by < 2; by++) begin
            for (int bx = 0; bx < 2; bx++) begin
                ix = PAN_X_START + dx + bx;
                iy = PAN_Y_START + dy + by;
                if (iy % 2 == 0 && ix % 2 == 0) begin
                    pixel.red = frame[iy][ix]; // RGGB with red at the sensor origin
                end else if (iy % 2 == 1 && ix % 2 == 1) begin
                    pixel.blue = frame[iy][ix];
                end else begin
                    green_sum = green_sum + {1'b0, frame[iy][ix]};
                end
            end
        end
        pixel.green = green_sum[10:1];
        return pixel;
    endfunction

    function automatic void finish_frame();
        rgb_pixel_t pixel;
        int         red_sum;
        int         green_sum;
        int         blue_sum;
        red_sum   = 0;
        green_sum = 0;
        blue_sum  = 0;
        for (int dy = 0; dy < DEBAYER_HEIGHT; dy++) begin
            for (int dx = 0; dx < DEBAYER_WIDTH; dx++) begin
                pixel     = debayer_pixel(dx, dy);
                red_sum   = red_sum + int'(pixel.red[9:2]);
                green_sum = green_sum + int'(pixel.green[9:2]);
                blue_sum  = blue_sum + int'(pixel.blue[9:2]);
            end
        end
        means.red   = 8'(red_sum >> LOG2_PIXELS);
        means.green = 8'(green_sum >> LOG2_PIXELS);
        means.blue  = 8'(blue_sum >> LOG2_PIXELS);
        if (capturing) begin
            for (int dy = ZOOM_Y_START; dy < ZOOM_Y_END; dy++) begin
                for (int dx = ZOOM_X_START; dx < ZOOM_X_END; dx++) begin
                    pixel = debayer_pixel(dx, dy);
                    if (captured.size() < 3 * BUFFER_PIXELS) begin
                        captured.push_back(pixel.red[9:2]);
                        captured.push_back(pixel.green[9:2]);
                        captured.push_back(pixel.blue[9:2]);
                    end
                end
            end
            capturing    = 1'b0;
            capture_done = 1'b1;
        end
    endfunction

    task automatic close_test(input string name);
        if (error_count == errors_at_close) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", name, error_count - errors_at_close);
        end
        errors_at_close = error_count;
    endtask

    task automatic report_counts();
        $display("Tests passed %0d, failed %0d; responses checked %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
    endtask

    always @(negedge mipi_byte_clock) begin
        if (!mipi_byte_reset_n) begin
            armed         = 1'b0;
            capturing     = 1'b0;
            capture_done  = 1'b0;
            pending       = 1'b0;
            frame_valid_d = 1'b0;
            line_valid_d  = 1'b0;
            read_index    = 0;
            means         = '0;
            captured.delete();
        end else begin
            if (pending) begin // Op code seen one cycle earlier
                check_count++;
                if (response_valid_i !== 1'b1) begin
                    error_count++;
                    $display("Op code 0x%02h got no response at %0t", pending_op, $time);
                end else if (response_i !== expected) begin
                    error_count++;
                    $display("CHECK FAILED response_o for op 0x%02h: expected 0x%02h, got 0x%02h",
                             pending_op, expected, response_i);
                end
            end else if (response_valid_i !== 1'b0) begin
                error_count++;
                $display("CHECK FAILED response_valid_o without op code: expected 0x0, got 0x%0h",
                         response_valid_i);
            end

            if (frame_valid_i && !frame_valid_d) begin
                x = 0;
                y = 0;
                if (armed) begin
                    armed     = 1'b0;
                    capturing = 1'b1;
                    captured.delete();
                end
            end
            if (frame_valid_i && line_valid_i) begin
                if (x < FRAME_WIDTH && y < FRAME_HEIGHT) begin
                    frame[y][x] = bayer_data_i;
                end
                x++;
            end
            if (line_valid_d && !line_valid_i) begin
                x = 0;
                y++;
            end
            if (frame_valid_d && !frame_valid_i) begin
                finish_frame();
            end
            frame_valid_d = frame_valid_i;
            line_valid_d  = line_valid_i;

            pending    = op_code_valid_i;
            pending_op = op_code_i;
            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_START_CAPTURE: begin
                        pending      = 1'b0;
                        armed        = 1'b1;
                        capture_done = 1'b0;
                        read_index   = 0;
                    end
                    OP_READ_STATUS:   expected = 8'(capture_done) << STATUS_CAPTURE_DONE;
                    OP_READ_RED:      expected = means.red;
                    OP_READ_GREEN:    expected = means.green;
                    OP_READ_BLUE:     expected = means.blue;
                    OP_READ_BYTES_HI: expected = 8'(captured.size() >> 8);
                    OP_READ_BYTES_LO: expected = 8'(captured.size());
                    OP_READ_DATA: begin
                        expected = read_index < captured.size() ? captured[read_index] : 8'h00;
                        read_index++;
                    end
                    OP_RESET_READ: begin
                        expected   = RESPONSE_ACK;
                        read_index = 0;
                    end
                    default: pending = 1'b0; // Unknown codes stay silent
                endcase
            end
        end
    end

endmodule

// File: camera_tb.sv
/* Camera testbench. Sends 24x24 random Bayer frames, with op codes between frames apart from
   one status read during a capture; the camera_checker instance models the pipeline */
`timescale 1ns/1ps

module camera_tb import camera_registers_pkg::*; ();

    localparam int FRAME_WIDTH     = 24;
    localparam int FRAME_HEIGHT    = 24;
    localparam int FRAME_CYCLES    = FRAME_HEIGHT * (FRAME_WIDTH + 6) + 14; // Longest blanking
    localparam int READOUT_CYCLES  = 3 * 340;                  // Three cycles per op code
    localparam int WATCHDOG_CYCLES = 2 * (8 * FRAME_CYCLES + READOUT_CYCLES);

    logic       mipi_byte_clock;
    logic       mipi_byte_reset_n;
    logic       frame_valid;
    logic       line_valid;
    logic [9:0] bayer_data;
    logic [7:0] op_code;
    logic       op_code_valid;
    logic [7:0] response;
    logic       response_valid;
    integer     seed;

    camera camera_i (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(frame_valid), .line_valid_i(line_valid), .bayer_data_i(bayer_data),
        .op_code_i(op_code), .op_code_valid_i(op_code_valid),
        .response_o(response), .response_valid_o(response_valid)
    );

    camera_checker #(.FRAME_WIDTH(FRAME_WIDTH), .FRAME_HEIGHT(FRAME_HEIGHT)) camera_checks (
        .mipi_byte_clock, .mipi_byte_reset_n,
        .frame_valid_i(frame_valid), .line_valid_i(line_valid), .bayer_data_i(bayer_data),
        .op_code_i(op_code), .op_code_valid_i(op_code_valid),
        .response_i(response), .response_valid_i(response_valid)
    );

    initial begin
        mipi_byte_clock = 1'b0;
        forever #10 mipi_byte_clock = ~mipi_byte_clock;
    end

    // Lines have 2 to 5 blanking cycles and frames at least 10
    task automatic send_frame();
        int gap;
        @(posedge mipi_byte_clock);
        frame_valid <= 1'b1;
        for (int row = 0; row < FRAME_HEIGHT; row++) begin
            gap = 1 + int'($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge mipi_byte_clock);
            for (int column = 0; column < FRAME_WIDTH; column++) begin
                @(posedge mipi_byte_clock);
                line_valid <= 1'b1;
                bayer_data <= 10'($random(seed));
            end
            @(posedge mipi_byte_clock);
            line_valid <= 1'b0;
        end
        repeat (2) @(posedge mipi_byte_clock);
        frame_valid <= 1'b0;
        repeat (10) @(posedge mipi_byte_clock);
    endtask

    task automatic issue_op(input logic [7:0] code);
        @(posedge mipi_byte_clock);
        op_code       <= code;
        op_code_valid <= 1'b1;
        @(posedge mipi_byte_clock);
        op_code_valid <= 1'b0;
        @(posedge mipi_byte_clock); // Response cycle
    endtask

    task automatic read_metering();
        issue_op(OP_READ_RED);
        issue_op(OP_READ_GREEN);
        issue_op(OP_READ_BLUE);
    endtask

    task automatic read_capture_state();
        issue_op(OP_READ_STATUS);
        issue_op(OP_READ_BYTES_HI);
        issue_op(OP_READ_BYTES_LO);
    endtask

    task automatic read_bytes(input int count);
        repeat (count) issue_op(OP_READ_DATA);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge mipi_byte_clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed              = 32'hcee2f299;
        mipi_byte_reset_n = 1'b0;
        frame_valid       = 1'b0;
        line_valid        = 1'b0;
        bayer_data        = '0;
        op_code           = '0;
        op_code_valid     = 1'b0;
        repeat (4) @(posedge mipi_byte_clock);
        mipi_byte_reset_n <= 1'b1;
        repeat (2) @(posedge mipi_byte_clock);

        read_capture_state();
        read_metering();
        issue_op(8'h7f); // Unknown code gives no response
        repeat (8) @(posedge mipi_byte_clock);
        camera_checks.close_test("reset values and idle response");

        send_frame();
        read_metering();
        camera_checks.close_test("metering of one frame");

        issue_op(OP_START_CAPTURE);
        send_frame();
        read_capture_state();
        camera_checks.close_test("capture done and byte count");

        read_bytes(144);
        camera_checks.close_test("readout of the zoomed frame");

        issue_op(OP_RESET_READ);
        read_bytes(9);
        issue_op(OP_START_CAPTURE);
        fork
            send_frame();
            begin
                repeat (300) @(posedge mipi_byte_clock);
                issue_op(OP_READ_STATUS); // Capture still running at this point
            end
        join
        read_capture_state();
        read_metering();
        read_bytes(144);
        camera_checks.close_test("rewind and second capture");

        camera_checks.report_counts();
        if (camera_checks.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
camera_pipeline_pkg.sv
camera_registers_pkg.sv
buffer_read_if.sv
crop.sv
debayer.sv
metering.sv
image_buffer.sv
spi_registers.sv
camera.sv
camera_checker.sv
camera_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the camera testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module camera_tb -f compile.f -o camera_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/camera_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1
